// ==== include/afifo_defines.svh ====
`ifndef AFIFO_DEFINES_SVH
`define AFIFO_DEFINES_SVH

// ==========================================================================
// FIFO geometry
// ==========================================================================

// Data word width
`define AFIFO_WIDTH 16

// Pointer and address width
`define AFIFO_ADDR_BITS 8

// Entry count, power of two
`define AFIFO_DEPTH (1 << `AFIFO_ADDR_BITS)

// Ready filter depths, write side and read side
`define AFIFO_WR_READY_STAGES 2
`define AFIFO_RD_READY_STAGES 3

`endif

// ==== hdl/afifo_pkg.sv ====
`include "afifo_defines.svh"

package afifo_pkg;

    // ======================================================================
    // Pointer bundle
    // ======================================================================

    // Binary count, Gray copy, and Gray copy one cycle later
    typedef struct packed {
        logic [`AFIFO_ADDR_BITS-1:0] bin;
        logic [`AFIFO_ADDR_BITS-1:0] gray;
        logic [`AFIFO_ADDR_BITS-1:0] gray_dly;
    } ptr_t;

    // ======================================================================
    // Port bundles
    // ======================================================================

    // Write strobe with its data word
    typedef struct packed {
        logic                    trigger;
        logic [`AFIFO_WIDTH-1:0] data;
    } wr_req_t;

    // Head word with its ready level
    typedef struct packed {
        logic                    ready;
        logic [`AFIFO_WIDTH-1:0] data;
    } rd_rsp_t;

endpackage

// ==== hdl/gray_ptr.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module gray_ptr (
    input  logic                        clk,
    input  logic                        a_dirClr,
    input  logic                        inc,
    output logic [`AFIFO_ADDR_BITS-1:0] next_bin,
    output afifo_pkg::ptr_t             ptr
);

    logic [`AFIFO_ADDR_BITS-1:0] next_gray;

    // ======================================================================
    // Next value
    // ======================================================================

    // Advance by one on an accepted access, wrap is natural
    assign next_bin = ptr.bin + {{(`AFIFO_ADDR_BITS-1){1'b0}}, inc};

    // Binary to Gray on the incoming value, so Gray is a clean register
    assign next_gray = next_bin ^ (next_bin >> 1);

    // ======================================================================
    // Pointer registers
    // ======================================================================

    always_ff @(posedge clk or posedge a_dirClr) begin
        if (a_dirClr) begin
            ptr.bin      <= '0;
            ptr.gray     <= '0;
            ptr.gray_dly <= '0;
        end else begin
            ptr.bin  <= next_bin;
            ptr.gray <= next_gray;
            // Delayed copy, sampled by the opposite domain
            ptr.gray_dly <= ptr.gray;
        end
    end

endmodule

// ==== hdl/afifo_wr_ctrl.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module afifo_wr_ctrl (
    input  logic               w_clk,
    input  logic               a_dirClr,
    input  afifo_pkg::wr_req_t w_req,
    input  logic               full_n,
    output logic               w_ready,
    output logic               wr_en,
    output afifo_pkg::ptr_t    wr_ptr
);

    // Busy history, a one here means recently full
    logic [`AFIFO_WR_READY_STAGES-1:0] busy_sr;

    // ======================================================================
    // Write qualification
    // ======================================================================

    // Strobe counts only while space is reported
    assign wr_en = w_req.trigger & w_ready;

    // Write pointer, binary form addresses the RAM
    gray_ptr u_wr_ptr (
        .clk      (w_clk),
        .a_dirClr (a_dirClr),
        .inc      (wr_en),
        .next_bin (),
        .ptr      (wr_ptr)
    );

    // ======================================================================
    // w_ready filter
    // ======================================================================

    // Full sets every stage at once
    // After full clears, zeros walk through the stages
    always_ff @(posedge w_clk or posedge a_dirClr or negedge full_n) begin
        if (a_dirClr) begin
            busy_sr <= '0;
        end else if (!full_n) begin
            busy_sr <= '1;
        end else begin
            busy_sr <= busy_sr << 1;
        end
    end

    // Ready only when the last stage has drained
    assign w_ready = ~busy_sr[`AFIFO_WR_READY_STAGES-1];

endmodule

// ==== hdl/afifo_rd_ctrl.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module afifo_rd_ctrl (
    input  logic                        r_clk,
    input  logic                        a_dirClr,
    input  logic                        r_trigger,
    input  logic                        empty_n,
    output logic                        r_ready,
    output afifo_pkg::ptr_t             rd_ptr,
    output logic [`AFIFO_ADDR_BITS-1:0] rd_addr_next
);

    // Availability history, a one here means data seen
    logic [`AFIFO_RD_READY_STAGES-1:0] avail_sr;
    logic                              rd_en;

    // ======================================================================
    // Read qualification
    // ======================================================================

    // Pop only while data is reported
    assign rd_en = r_trigger & r_ready;

    // Read pointer
    // next_bin goes to the RAM so the head word is already registered
    gray_ptr u_rd_ptr (
        .clk      (r_clk),
        .a_dirClr (a_dirClr),
        .inc      (rd_en),
        .next_bin (rd_addr_next),
        .ptr      (rd_ptr)
    );

    // ======================================================================
    // r_ready filter
    // ======================================================================

    // Empty clears every stage at once
    // Ones walk in after that, three clean cycles before ready
    always_ff @(posedge r_clk or posedge a_dirClr or negedge empty_n) begin
        if (a_dirClr) begin
            avail_sr <= '0;
        end else if (!empty_n) begin
            avail_sr <= '0;
        end else begin
            avail_sr <= {avail_sr[`AFIFO_RD_READY_STAGES-2:0], 1'b1};
        end
    end

    // Last stage is the level seen outside
    assign r_ready = avail_sr[`AFIFO_RD_READY_STAGES-1];

endmodule

// ==== hdl/afifo_dir.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module afifo_dir (
    input  logic            a_dirClr,
    input  afifo_pkg::ptr_t wr_ptr,
    input  afifo_pkg::ptr_t rd_ptr,
    output logic            full_n,
    output logic            empty_n
);

    localparam int MSB = `AFIFO_ADDR_BITS - 1;

    logic dir_set_cond;
    logic dir_clr_cond;
    // High means the writer is catching up on the reader
    logic dir_flag;

    // ======================================================================
    // Quadrant compare
    // ======================================================================

    // Writer one quadrant behind the reader, heading for full
    assign dir_set_cond = (wr_ptr.gray[MSB] ^ rd_ptr.gray_dly[MSB-1]) &
                          ~(wr_ptr.gray[MSB-1] ^ rd_ptr.gray_dly[MSB]);

    // Writer one quadrant ahead of the reader, heading for empty
    assign dir_clr_cond = ~(wr_ptr.gray_dly[MSB] ^ rd_ptr.gray[MSB-1]) &
                          (wr_ptr.gray_dly[MSB-1] ^ rd_ptr.gray[MSB]);

    // ======================================================================
    // Direction flag
    // ======================================================================

    // Edge set, edge or reset cleared, no clock involved
    always_ff @(posedge dir_set_cond or posedge dir_clr_cond or posedge a_dirClr) begin
        if (a_dirClr) begin
            dir_flag <= 1'b0;
        end else if (dir_clr_cond) begin
            dir_flag <= 1'b0;
        end else begin
            dir_flag <= 1'b1;
        end
    end

    // Raw status, equal pointers split by direction
    assign full_n  = ~((wr_ptr.gray == rd_ptr.gray_dly) & dir_flag);
    assign empty_n = ~((wr_ptr.gray_dly == rd_ptr.gray) & ~dir_flag);

endmodule

// ==== hdl/afifo_ram.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module afifo_ram (
    input  logic                        w_clk,
    input  logic                        wr_en,
    input  logic [`AFIFO_ADDR_BITS-1:0] wr_addr,
    input  logic [`AFIFO_WIDTH-1:0]     wr_data,
    input  logic                        r_clk,
    input  logic [`AFIFO_ADDR_BITS-1:0] rd_addr,
    output logic [`AFIFO_WIDTH-1:0]     rd_data
);

    // ======================================================================
    // Storage
    // ======================================================================

    logic [`AFIFO_WIDTH-1:0] mem [`AFIFO_DEPTH];

    // Write port, w_clk domain
    always_ff @(posedge w_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, r_clk domain
    // Always enabled, address is the look-ahead pointer
    always_ff @(posedge r_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== hdl/afifo.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module afifo (
    // Write side
    input  logic               w_clk,
    input  afifo_pkg::wr_req_t w_req,
    output logic               w_ready,
    // Read side
    input  logic               r_clk,
    input  logic               r_trigger,
    output afifo_pkg::rd_rsp_t r_rsp,
    // Shared reset
    input  logic               a_dirClr
);

    afifo_pkg::ptr_t             wr_ptr;
    afifo_pkg::ptr_t             rd_ptr;
    logic                        wr_en;
    logic [`AFIFO_ADDR_BITS-1:0] rd_addr_next;
    logic                        full_n;
    logic                        empty_n;
    logic                        r_ready;
    logic [`AFIFO_WIDTH-1:0]     rd_data;

    // ======================================================================
    // Domain controls
    // ======================================================================

    afifo_wr_ctrl u_wr_ctrl (
        .w_clk    (w_clk),
        .a_dirClr (a_dirClr),
        .w_req    (w_req),
        .full_n   (full_n),
        .w_ready  (w_ready),
        .wr_en    (wr_en),
        .wr_ptr   (wr_ptr)
    );

    afifo_rd_ctrl u_rd_ctrl (
        .r_clk        (r_clk),
        .a_dirClr     (a_dirClr),
        .r_trigger    (r_trigger),
        .empty_n      (empty_n),
        .r_ready      (r_ready),
        .rd_ptr       (rd_ptr),
        .rd_addr_next (rd_addr_next)
    );

    // ======================================================================
    // Status and storage
    // ======================================================================

    // Asynchronous full and empty from both pointers
    afifo_dir u_dir (
        .a_dirClr (a_dirClr),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .full_n   (full_n),
        .empty_n  (empty_n)
    );

    afifo_ram u_ram (
        .w_clk   (w_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_ptr.bin),
        .wr_data (w_req.data),
        .r_clk   (r_clk),
        .rd_addr (rd_addr_next),
        .rd_data (rd_data)
    );

    // Read response bundle
    assign r_rsp = '{ready: r_ready, data: rd_data};

endmodule

// ==== tests/afifo_tb.sv ====
`timescale 1ns/1ps
`include "afifo_defines.svh"

module afifo_tb;

    localparam int DW            = `AFIFO_WIDTH;
    localparam int DEPTH         = `AFIFO_DEPTH;
    localparam int R_PERIOD      = 4;
    localparam int W_PERIOD      = 6;
    localparam int RANDOM_CYCLES = 2000;
    localparam int FILL_LIMIT    = DEPTH + 16;
    localparam int DRAIN_LIMIT   = 4 * DEPTH + 64;
    // Stimulus modes for both drivers
    localparam int MODE_IDLE     = 0;
    localparam int MODE_STEADY   = 1;
    localparam int MODE_RANDOM   = 2;
    // Worst case per test, in order: reset, ordering, full, empty, random
    localparam int TEST_NS = 12 * R_PERIOD
                           + 36 * W_PERIOD + 16 * R_PERIOD + DRAIN_LIMIT * R_PERIOD
                           + (FILL_LIMIT + 6) * W_PERIOD + DRAIN_LIMIT * R_PERIOD
                           + 24 * R_PERIOD
                           + (RANDOM_CYCLES + 2) * W_PERIOD + DRAIN_LIMIT * R_PERIOD;
    localparam int WATCHDOG_NS = 2 * TEST_NS;

    logic               r_clk;
    logic               w_clk;
    logic               a_dirClr;
    logic               r_trigger;
    logic               w_ready;
    afifo_pkg::wr_req_t w_req;
    afifo_pkg::rd_rsp_t r_rsp;

    // Reference model, oldest word at the front
    logic [DW-1:0] model_q[$];
    logic [DW-1:0] exp_word;
    int            wr_count;
    int            rd_count;
    int            n_checks;
    int            n_errors;
    int            n_tests;
    int            wr_mode;
    int            rd_mode;
    logic          rd_heavy;
    logic          checks_on;

    afifo i_dut (
        .w_clk     (w_clk),
        .w_req     (w_req),
        .w_ready   (w_ready),
        .r_clk     (r_clk),
        .r_trigger (r_trigger),
        .r_rsp     (r_rsp),
        .a_dirClr  (a_dirClr)
    );

    // ======================================================================
    // Clocks and watchdog
    // ======================================================================

    initial begin
        r_clk = 1'b0;
        forever #(R_PERIOD / 2) r_clk = ~r_clk;
    end

    initial begin
        w_clk = 1'b0;
        forever #(W_PERIOD / 2) w_clk = ~w_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test never finished", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    // ======================================================================
    // Check helpers
    // ======================================================================

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s", msg);
        n_errors++;
    endtask

    task automatic end_test(input string name, input int err_base);
        n_tests++;
        $display("test %-15s done, %0d new errors", name, n_errors - err_base);
    endtask

    // Bounded waits, sampled mid-cycle where everything is settled
    task automatic wait_writes(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (wr_count < target && cycles < limit) begin
            @(negedge w_clk);
            cycles++;
        end
        if (wr_count < target) begin
            report_error($sformatf("only %0d of %0d writes accepted in %0d w_clk cycles",
                                   wr_count, target, limit));
        end
    endtask

    task automatic wait_ready_rise(input int limit);
        int cycles;
        cycles = 0;
        while (!r_rsp.ready && cycles < limit) begin
            @(negedge r_clk);
            cycles++;
        end
        if (!r_rsp.ready) begin
            report_error($sformatf("r_rsp.ready did not rise within %0d r_clk cycles", limit));
        end
    endtask

    task automatic wait_model_empty(input int limit);
        int cycles;
        cycles = 0;
        while (model_q.size() != 0 && cycles < limit) begin
            @(negedge r_clk);
            cycles++;
        end
        if (model_q.size() != 0) begin
            report_error($sformatf("%0d words still unread after %0d r_clk cycles",
                                   model_q.size(), limit));
        end
    endtask

    // ======================================================================
    // Drivers, one per clock domain
    // ======================================================================

    always @(posedge w_clk) begin
        case (wr_mode)
            MODE_STEADY: begin
                w_req.trigger <= 1'b1;
                w_req.data    <= DW'($urandom);
            end
            MODE_RANDOM: begin
                // Three writes in four cycles
                w_req.trigger <= ($urandom_range(3) != 0);
                w_req.data    <= DW'($urandom);
            end
            default: begin
                w_req.trigger <= 1'b0;
            end
        endcase
    end

    always @(posedge r_clk) begin
        case (rd_mode)
            MODE_STEADY: r_trigger <= 1'b1;
            // Slow reader lets the FIFO fill, fast one drains it
            MODE_RANDOM: r_trigger <= rd_heavy ? ($urandom_range(3) != 0)
                                               : ($urandom_range(3) == 0);
            default:     r_trigger <= 1'b0;
        endcase
    end

    // ======================================================================
    // Monitors and reference model
    // ======================================================================

    always @(posedge w_clk) begin
        if (checks_on) begin
            // Nothing stored, so space must be reported
            if (model_q.size() == 0) begin
                expect_eq("w_ready", w_ready, 1);
            end
            if (w_req.trigger && w_ready) begin
                model_q.push_back(w_req.data);
                wr_count++;
            end
        end
    end

    always @(posedge r_clk) begin
        if (checks_on) begin
            if (model_q.size() == 0) begin
                expect_eq("r_rsp.ready", r_rsp.ready, 0);
            end
            if (r_trigger && r_rsp.ready) begin
                if (model_q.size() == 0) begin
                    report_error("read accepted with no word left in the model");
                end else begin
                    // Head word must already sit on the data output
                    exp_word = model_q.pop_front();
                    expect_eq("r_rsp.data", r_rsp.data, exp_word);
                    rd_count++;
                end
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        int base_wr;
        int base_rd;
        int err_base;
        void'($urandom(32'he285_7312));
        a_dirClr  = 1'b1;
        w_req     = '0;
        r_trigger = 1'b0;
        wr_mode   = MODE_IDLE;
        rd_mode   = MODE_IDLE;
        rd_heavy  = 1'b0;
        checks_on = 1'b0;
        wr_count  = 0;
        rd_count  = 0;
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        repeat (10) @(posedge r_clk);
        a_dirClr <= 1'b0;

        // Reset state, empty FIFO
        err_base = n_errors;
        @(negedge r_clk);
        @(negedge w_clk);
        checks_on = 1'b1;
        expect_eq("r_rsp.ready", r_rsp.ready, 0);
        expect_eq("w_ready", w_ready, 1);
        end_test("reset_state", err_base);

        // Short burst, then read back in order
        err_base = n_errors;
        base_wr  = wr_count;
        wr_mode <= MODE_STEADY;
        wait_writes(base_wr + 16, 32);
        wr_mode <= MODE_IDLE;
        repeat (2) @(negedge w_clk);
        wait_ready_rise(16);
        rd_mode <= MODE_STEADY;
        wait_model_empty(DRAIN_LIMIT);
        rd_mode <= MODE_IDLE;
        expect_eq("read count", rd_count, wr_count);
        end_test("ordering", err_base);

        // Fill to the brim, keep pushing, then drain
        err_base = n_errors;
        base_wr  = wr_count;
        base_rd  = rd_count;
        wr_mode <= MODE_STEADY;
        wait_writes(base_wr + DEPTH, FILL_LIMIT);
        repeat (4) @(negedge w_clk);
        expect_eq("w_ready", w_ready, 0);
        expect_eq("accepted writes", wr_count - base_wr, DEPTH);
        wr_mode <= MODE_IDLE;
        @(negedge w_clk);
        rd_mode <= MODE_STEADY;
        wait_model_empty(DRAIN_LIMIT);
        expect_eq("drained words", rd_count - base_rd, DEPTH);
        end_test("full", err_base);

        // Reader keeps strobing on an empty FIFO
        err_base = n_errors;
        repeat (24) @(negedge r_clk);
        expect_eq("r_rsp.ready", r_rsp.ready, 0);
        rd_mode <= MODE_IDLE;
        end_test("empty", err_base);

        // Random traffic, write-heavy half then read-heavy half
        err_base = n_errors;
        wr_mode <= MODE_RANDOM;
        rd_mode <= MODE_RANDOM;
        repeat (RANDOM_CYCLES / 2) @(negedge w_clk);
        rd_heavy <= 1'b1;
        repeat (RANDOM_CYCLES / 2) @(negedge w_clk);
        wr_mode <= MODE_IDLE;
        repeat (2) @(negedge w_clk);
        rd_mode <= MODE_STEADY;
        wait_model_empty(DRAIN_LIMIT);
        rd_mode <= MODE_IDLE;
        expect_eq("read count", rd_count, wr_count);
        end_test("random_traffic", err_base);

        $display("tests=%0d checks=%0d errors=%0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/afifo_pkg.sv
hdl/gray_ptr.sv
hdl/afifo_wr_ctrl.sv
hdl/afifo_rd_ctrl.sv
hdl/afifo_dir.sv
hdl/afifo_ram.sv
hdl/afifo.sv
tests/afifo_tb.sv
